// ==== board_pkg.sv ====
// shared widths, bit positions and joystick types, imported by the board RTL and its testbench
`default_nettype none

package board_pkg;

    // joystick ports on the board
    localparam int NUM_PLAYERS = 4;

    // word widths
    localparam int RAW_JOY_W  = 16;   // joystick word from the board side
    localparam int GAME_JOY_W = 10;   // word handed to the game core
    localparam int DIR_W      = 4;    // direction group at the bottom of both words

    // direction bit positions inside a joystick word
    localparam int DIR_RIGHT = 0;
    localparam int DIR_LEFT  = 1;
    localparam int DIR_DOWN  = 2;
    localparam int DIR_UP    = 3;

    // layer enables driven by the front panel
    localparam int GFX_LAYERS = 4;

    // raw joystick from the board, active high
    typedef logic [RAW_JOY_W-1:0] raw_joy_t;

    // joystick word as the game core sees it
    typedef logic [GAME_JOY_W-1:0] game_joy_t;

    // right, left, down, up
    typedef logic [DIR_W-1:0] dir_t;

endpackage

`default_nettype wire

// ==== board_reset.sv ====
// game reset sequencer, stretches any reset source into a fixed-length game reset on clk_sys
`default_nettype none
`timescale 1ns/1ns

module board_reset #(
    parameter int GAME_RST_LEN = 32
) (
    input  logic clk_sys,
    input  logic rst,
    input  logic rst_req,       // reset request from the frame
    input  logic downloading,   // rom load in progress
    input  logic soft_rst,      // one-cycle pulse from the panel
    output logic game_rst
);

    localparam int CNT_W = $clog2(GAME_RST_LEN + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(GAME_RST_LEN);

    logic             trigger;
    logic [CNT_W-1:0] rst_cnt;

    // any source restarts the stretch
    assign trigger = rst | rst_req | downloading | soft_rst;

    always_ff @(posedge clk_sys) begin
        if (trigger) begin
            rst_cnt  <= '0;
            game_rst <= 1'b1;
        end else if (rst_cnt != CNT_LAST) begin
            rst_cnt  <= rst_cnt + 1'b1;
            game_rst <= 1'b1;
        end else begin
            game_rst <= 1'b0;   // stretch done
        end
    end

    // a reset source must always reach the game on the following edge
    a_trigger_rst: assert property (@(posedge clk_sys) trigger |=> game_rst)
        else $error("game_rst low one cycle after a reset source");

endmodule

`default_nettype wire

// ==== joy_4way.sv ====
// per-player 4-way direction filter, remembers the last single direction held on a diagonal
`default_nettype none
`timescale 1ns/1ns

module joy_4way
    import board_pkg::*;
(
    input  logic clk_sys,
    input  logic rst,
    input  logic enable,    // 4-way mode on
    input  dir_t dir_in,
    output dir_t dir_out
);

    dir_t next_dir;

    function automatic logic is_onehot(dir_t d);
        return (d != '0) && ((d & (d - DIR_W'(1))) == '0);
    endfunction

    always_comb begin
        if (!enable) begin
            next_dir = dir_in;      // 8-way pass through
        end else if (dir_in == '0) begin
            next_dir = '0;
        end else if (is_onehot(dir_in)) begin
            next_dir = dir_in;
        end else if (is_onehot(dir_out) && ((dir_out & dir_in) != '0)) begin
            // diagonal that still holds the old direction
            next_dir = dir_out;
        end else begin
            next_dir = '0;          // fresh diagonal gives nothing
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            dir_out <= '0;
        end else begin
            dir_out <= next_dir;
        end
    end

    // the game never sees a diagonal once 4-way mode is on
    a_four_way: assert property (@(posedge clk_sys) disable iff (rst)
        enable |=> $onehot0(dir_out))
        else $error("4-way output has more than one direction");

endmodule

`default_nettype wire

// ==== joy_mapper.sv ====
// player input mapper, turns four board joysticks into game joysticks, coins, starts and pause
`default_nettype none
`timescale 1ns/1ns

module joy_mapper
    import board_pkg::*;
#(
    parameter int BUTTONS    = 2,
    parameter bit ACTIVE_LOW = 1'b1
) (
    input  logic      clk_sys,
    input  logic      rst,
    input  logic      en4way,
    input  logic      rot_control,  // vertical game on a horizontal screen
    input  logic      flip,
    input  raw_joy_t  board_joystick [NUM_PLAYERS],
    output game_joy_t game_joystick  [NUM_PLAYERS],
    output logic [NUM_PLAYERS-1:0] game_coin,
    output logic [NUM_PLAYERS-1:0] game_start,
    output logic      joy_pause     // level, players 1 and 2
);

    // buttons sit above the directions, then start, coin and pause
    localparam int START_BIT = 6 + (BUTTONS - 2);
    localparam int COIN_BIT  = 7 + (BUTTONS - 2);
    localparam int PAUSE_BIT = 8 + (BUTTONS - 2);

    dir_t                     joy_dir   [NUM_PLAYERS];
    logic [RAW_JOY_W-1:DIR_W] joy_upper [NUM_PLAYERS];
    raw_joy_t                 joy_sync  [NUM_PLAYERS];

    // rotation and flip of the direction group, then polarity
    function automatic game_joy_t map_joy(game_joy_t s, logic rot, logic flp);
        game_joy_t r;
        r = s;
        if (rot && flp) begin
            r[DIR_UP]    = s[DIR_LEFT];
            r[DIR_DOWN]  = s[DIR_RIGHT];
            r[DIR_LEFT]  = s[DIR_DOWN];
            r[DIR_RIGHT] = s[DIR_UP];
        end else if (rot) begin
            r[DIR_UP]    = s[DIR_RIGHT];
            r[DIR_DOWN]  = s[DIR_LEFT];
            r[DIR_LEFT]  = s[DIR_UP];
            r[DIR_RIGHT] = s[DIR_DOWN];
        end
        return r ^ {GAME_JOY_W{ACTIVE_LOW}};
    endfunction

    for (genvar i = 0; i < NUM_PLAYERS; i++) begin : g_player
        joy_4way u_4way (
            .clk_sys ( clk_sys                        ),
            .rst     ( rst                            ),
            .enable  ( en4way                         ),
            .dir_in  ( board_joystick[i][DIR_W-1:0]   ),
            .dir_out ( joy_dir[i]                     )
        );

        assign joy_sync[i] = {joy_upper[i], joy_dir[i]};    // stage one word
    end

    // stage one, raw upper bits registered beside the 4-way register
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            for (int i = 0; i < NUM_PLAYERS; i++) begin
                joy_upper[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_PLAYERS; i++) begin
                joy_upper[i] <= board_joystick[i][RAW_JOY_W-1:DIR_W];
            end
        end
    end

    // stage two, game side words
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            for (int i = 0; i < NUM_PLAYERS; i++) begin
                game_joystick[i] <= {GAME_JOY_W{ACTIVE_LOW}};   // idle level
            end
            game_coin  <= {NUM_PLAYERS{ACTIVE_LOW}};
            game_start <= {NUM_PLAYERS{ACTIVE_LOW}};
        end else begin
            for (int i = 0; i < NUM_PLAYERS; i++) begin
                game_joystick[i] <= map_joy(joy_sync[i][GAME_JOY_W-1:0], rot_control, flip);
                game_coin[i]     <= joy_sync[i][COIN_BIT] ^ ACTIVE_LOW;
                game_start[i]    <= joy_sync[i][START_BIT] ^ ACTIVE_LOW;
            end
        end
    end

    assign joy_pause = joy_sync[0][PAUSE_BIT] | joy_sync[1][PAUSE_BIT];

endmodule

`default_nettype wire

// ==== panel_ctrl.sv ====
// front-panel control, holds pause, soft reset, service and graphics layer toggle state
`default_nettype none
`timescale 1ns/1ns

module panel_ctrl
    import board_pkg::*;
#(
    parameter bit ACTIVE_LOW = 1'b1
) (
    input  logic                  clk_sys,
    input  logic                  rst,
    input  logic                  downloading,
    input  logic                  key_pause,
    input  logic                  joy_pause,
    input  logic                  osd_pause,    // menu open
    input  logic                  key_reset,
    input  logic                  key_service,
    input  logic [GFX_LAYERS-1:0] key_gfx,
    output logic                  game_pause,
    output logic                  soft_rst,
    output logic                  game_service,
    output logic [GFX_LAYERS-1:0] gfx_en
);

    logic                  last_key_pause;
    logic                  last_joy_pause;
    logic                  last_osd_pause;
    logic                  last_key_reset;
    logic [GFX_LAYERS-1:0] last_gfx;
    logic                  pause_edge;
    logic                  osd_change;

    assign pause_edge = (key_pause & ~last_key_pause) | (joy_pause & ~last_joy_pause);
    assign osd_change = osd_pause ^ last_osd_pause;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            last_key_pause <= 1'b0;
            last_joy_pause <= 1'b0;
            last_osd_pause <= 1'b0;
            last_key_reset <= 1'b0;
            last_gfx       <= '0;
            game_pause     <= 1'b0;
            soft_rst       <= 1'b0;
            game_service   <= ACTIVE_LOW;
            gfx_en         <= '1;   // all layers shown
        end else begin
            last_key_pause <= key_pause;
            last_joy_pause <= joy_pause;
            last_osd_pause <= osd_pause;
            last_key_reset <= key_reset;
            last_gfx       <= key_gfx;

            soft_rst     <= key_reset & ~last_key_reset;
            game_service <= key_service ^ ACTIVE_LOW;
            gfx_en       <= gfx_en ^ (key_gfx & ~last_gfx);    // toggle per pressed key

            if (downloading) begin
                game_pause <= 1'b0;
            end else if (osd_change) begin
                game_pause <= osd_pause;    // menu wins over the keys
            end else if (pause_edge) begin
                game_pause <= ~game_pause;
            end
        end
    end

endmodule

`default_nettype wire

// ==== color_expand.sv ====
// pixel colour expander, widens game colour to 8 bits per channel on the pixel clock enable
`default_nettype none
`timescale 1ns/1ns

module color_expand #(
    parameter int COLORW = 4    // 3 to 8
) (
    input  logic              clk_sys,
    input  logic              rst,
    input  logic              pxl_cen,
    input  logic [COLORW-1:0] game_r,
    input  logic [COLORW-1:0] game_g,
    input  logic [COLORW-1:0] game_b,
    input  logic              lhbl,     // low during horizontal blank
    input  logic              lvbl,     // low during vertical blank
    input  logic              hs,
    input  logic              vs,
    output logic [7:0]        video_r,
    output logic [7:0]        video_g,
    output logic [7:0]        video_b,
    output logic              video_hs,
    output logic              video_vs,
    output logic              video_de
);

    // repeat the channel from its msb down until 8 bits are filled
    function automatic logic [7:0] widen(logic [COLORW-1:0] c);
        logic [7:0] w;
        for (int i = 0; i < 8; i++) begin
            w[7 - i] = c[COLORW - 1 - (i % COLORW)];
        end
        return w;
    endfunction

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            video_r  <= '0;
            video_g  <= '0;
            video_b  <= '0;
            video_hs <= 1'b0;
            video_vs <= 1'b0;
            video_de <= 1'b0;
        end else if (pxl_cen) begin
            video_r  <= widen(game_r);
            video_g  <= widen(game_g);
            video_b  <= widen(game_b);
            video_hs <= hs;
            video_vs <= vs;
            video_de <= lhbl & lvbl;    // active area only
        end
    end

endmodule

`default_nettype wire

// ==== board_top.sv ====
// arcade board wrapper top, ties reset, input mapping, panel and video blocks to the board pins
`default_nettype none
`timescale 1ns/1ns

module board_top
    import board_pkg::*;
#(
    parameter int BUTTONS      = 2,
    parameter bit ACTIVE_LOW   = 1'b1,
    parameter int COLORW       = 4,
    parameter int GAME_RST_LEN = 32
) (
    input  logic                   clk_sys,
    input  logic                   rst,
    input  logic                   rst_req,
    input  logic                   downloading,
    input  logic                   en4way,
    input  logic                   rot_control,
    input  logic                   flip,
    input  logic                   osd_pause,
    input  logic                   key_pause,
    input  logic                   key_reset,
    input  logic                   key_service,
    input  logic [GFX_LAYERS-1:0]  key_gfx,
    input  raw_joy_t               board_joystick1,
    input  raw_joy_t               board_joystick2,
    input  raw_joy_t               board_joystick3,
    input  raw_joy_t               board_joystick4,
    input  logic [COLORW-1:0]      game_r,
    input  logic [COLORW-1:0]      game_g,
    input  logic [COLORW-1:0]      game_b,
    input  logic                   lhbl,
    input  logic                   lvbl,
    input  logic                   hs,
    input  logic                   vs,
    input  logic                   pxl_cen,
    output logic                   game_rst,
    output game_joy_t              game_joystick1,
    output game_joy_t              game_joystick2,
    output game_joy_t              game_joystick3,
    output game_joy_t              game_joystick4,
    output logic [NUM_PLAYERS-1:0] game_coin,
    output logic [NUM_PLAYERS-1:0] game_start,
    output logic                   game_service,
    output logic                   game_pause,
    output logic [GFX_LAYERS-1:0]  gfx_en,
    output logic [7:0]             video_r,
    output logic [7:0]             video_g,
    output logic [7:0]             video_b,
    output logic                   video_hs,
    output logic                   video_vs,
    output logic                   video_de
);

    raw_joy_t  board_joy [NUM_PLAYERS];
    game_joy_t game_joy  [NUM_PLAYERS];
    logic      joy_pause;
    logic      soft_rst;

    assign board_joy[0] = board_joystick1;
    assign board_joy[1] = board_joystick2;
    assign board_joy[2] = board_joystick3;
    assign board_joy[3] = board_joystick4;

    assign game_joystick1 = game_joy[0];
    assign game_joystick2 = game_joy[1];
    assign game_joystick3 = game_joy[2];
    assign game_joystick4 = game_joy[3];

    board_reset #(.GAME_RST_LEN(GAME_RST_LEN)) u_reset (
        .clk_sys     ( clk_sys     ),
        .rst         ( rst         ),
        .rst_req     ( rst_req     ),
        .downloading ( downloading ),
        .soft_rst    ( soft_rst    ),
        .game_rst    ( game_rst    )
    );

    joy_mapper #(.BUTTONS(BUTTONS), .ACTIVE_LOW(ACTIVE_LOW)) u_joy (
        .clk_sys        ( clk_sys     ),
        .rst            ( rst         ),
        .en4way         ( en4way      ),
        .rot_control    ( rot_control ),
        .flip           ( flip        ),
        .board_joystick ( board_joy   ),
        .game_joystick  ( game_joy    ),
        .game_coin      ( game_coin   ),
        .game_start     ( game_start  ),
        .joy_pause      ( joy_pause   )
    );

    panel_ctrl #(.ACTIVE_LOW(ACTIVE_LOW)) u_panel (
        .clk_sys      ( clk_sys      ),
        .rst          ( rst          ),
        .downloading  ( downloading  ),
        .key_pause    ( key_pause    ),
        .joy_pause    ( joy_pause    ),
        .osd_pause    ( osd_pause    ),
        .key_reset    ( key_reset    ),
        .key_service  ( key_service  ),
        .key_gfx      ( key_gfx      ),
        .game_pause   ( game_pause   ),
        .soft_rst     ( soft_rst     ),
        .game_service ( game_service ),
        .gfx_en       ( gfx_en       )
    );

    color_expand #(.COLORW(COLORW)) u_color (
        .clk_sys  ( clk_sys  ),
        .rst      ( rst      ),
        .pxl_cen  ( pxl_cen  ),
        .game_r   ( game_r   ),
        .game_g   ( game_g   ),
        .game_b   ( game_b   ),
        .lhbl     ( lhbl     ),
        .lvbl     ( lvbl     ),
        .hs       ( hs       ),
        .vs       ( vs       ),
        .video_r  ( video_r  ),
        .video_g  ( video_g  ),
        .video_b  ( video_b  ),
        .video_hs ( video_hs ),
        .video_vs ( video_vs ),
        .video_de ( video_de )
    );

endmodule

`default_nettype wire

// ==== tb_board.sv ====
// self-checking testbench for board_top, a cycle model of the board is compared with the DUT
`default_nettype none
`timescale 1ns/1ns

module tb_board
    import board_pkg::*;
();

    localparam int BUTTONS      = 2;
    localparam bit ACTIVE_LOW   = 1'b1;
    localparam int COLORW       = 4;
    localparam int GAME_RST_LEN = 32;
    localparam int START_BIT    = 6 + (BUTTONS - 2);
    localparam int COIN_BIT     = 7 + (BUTTONS - 2);
    localparam int PAUSE_BIT    = 8 + (BUTTONS - 2);
    localparam int N_JOY        = 200;
    localparam int N_COLOR      = 90;
    // tests take about 5 + 5 stretches of ~35 + N_JOY + 100 + N_COLOR, under 600 cycles
    localparam int CYCLE_LIMIT  = 4000;

    logic clk_sys, rst, rst_req, downloading, en4way, rot_control, flip;
    logic osd_pause, key_pause, key_reset, key_service, pxl_cen;
    logic lhbl, lvbl, hs, vs;
    logic [GFX_LAYERS-1:0]  key_gfx;
    logic [COLORW-1:0]      game_r, game_g, game_b;
    raw_joy_t               joy_in  [NUM_PLAYERS];
    game_joy_t              joy_out [NUM_PLAYERS];
    logic                   game_rst, game_service, game_pause;
    logic [NUM_PLAYERS-1:0] game_coin, game_start;
    logic [GFX_LAYERS-1:0]  gfx_en;
    logic [7:0]             video_r, video_g, video_b;
    logic                   video_hs, video_vs, video_de;

    // model state, mirrors what the board holds after each edge
    logic                   p_rst = 1'b1;   // first edge sees rst
    logic                   p_req, p_dl, p_en, p_rot, p_flip, p_osd, p_kp, p_kr, p_ks, p_cen;
    logic                   p_lhbl, p_lvbl, p_hs, p_vs;
    logic [GFX_LAYERS-1:0]  p_gfx;
    logic [COLORW-1:0]      p_r, p_g, p_b;
    raw_joy_t               p_joy  [NUM_PLAYERS];
    raw_joy_t               m_sync [NUM_PLAYERS];
    dir_t                   m_dir  [NUM_PLAYERS];
    game_joy_t              e_joy  [NUM_PLAYERS];
    logic [NUM_PLAYERS-1:0] e_coin, e_start;
    logic                   e_pause, e_service, e_rst, e_hs, e_vs, e_de;
    logic [GFX_LAYERS-1:0]  e_gfx, m_lgfx;
    logic [7:0]             e_r, e_g, e_b;
    logic                   m_lkp, m_ljp, m_losd, m_lkr, m_soft, jp, trig;
    int                     m_cnt;

    logic [31:0] lfsr = 32'h3576;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    logic        chk_on = 1'b0;

    board_top #(
        .BUTTONS(BUTTONS), .ACTIVE_LOW(ACTIVE_LOW), .COLORW(COLORW), .GAME_RST_LEN(GAME_RST_LEN)
    ) dut0 (
        .*,
        .board_joystick1 ( joy_in[0]  ),
        .board_joystick2 ( joy_in[1]  ),
        .board_joystick3 ( joy_in[2]  ),
        .board_joystick4 ( joy_in[3]  ),
        .game_joystick1  ( joy_out[0] ),
        .game_joystick2  ( joy_out[1] ),
        .game_joystick3  ( joy_out[2] ),
        .game_joystick4  ( joy_out[3] )
    );

    initial begin
        clk_sys = 1'b0;
        forever #4 clk_sys = ~clk_sys;
    end

    // galois lfsr, x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // output bits 3..0 picked from the sync bits, then polarity
    function automatic game_joy_t joy_ref(game_joy_t s, logic rot, logic flp);
        game_joy_t r;
        r = s;
        if (rot) begin
            r[3:0] = flp ? {s[1], s[0], s[2], s[3]} : {s[0], s[1], s[3], s[2]};
        end
        return r ^ {GAME_JOY_W{ACTIVE_LOW}};
    endfunction

    function automatic dir_t four_way_ref(logic en, dir_t d, dir_t last);
        if (!en || $countones(d) <= 1) begin
            return d;
        end
        if ($countones(last) == 1 && (d & last) != '0) begin
            return last;    // old direction still held
        end
        return '0;
    endfunction

    function automatic logic pause_ref(logic cur, logic dl, logic osd, logic last_osd, logic press);
        if (dl) begin
            return 1'b0;
        end
        if (osd != last_osd) begin
            return osd;
        end
        return press ? !cur : cur;
    endfunction

    // left-aligned copies of the channel, top 8 bits kept
    function automatic logic [7:0] widen_ref(logic [COLORW-1:0] c);
        int          reps;
        logic [15:0] acc;
        reps = (8 + COLORW - 1) / COLORW;
        acc  = '0;
        for (int n = 0; n < reps; n++) begin
            acc = (acc << COLORW) | 16'(c);
        end
        return 8'(acc >> (reps * COLORW - 8));
    endfunction

    task automatic check_val(string name, logic [31:0] exp, logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("** Error %s at %0t: expected %0h, actual %0h", name, $time, exp, act);
        end
    endtask

    task automatic tick(int n);
        repeat (n) begin
            @(posedge clk_sys);
            #1;
        end
    endtask

    // edges until game_rst drops, the falling edge included
    task automatic count_stretch(string name);
        int n;
        n = 0;
        while (game_rst === 1'b1 && n < 4 * GAME_RST_LEN) begin
            tick(1);
            n++;
        end
        check_val(name, 32'(GAME_RST_LEN + 1), 32'(n));
    endtask

    task automatic press_dir(dir_t d, dir_t exp, string name);
        joy_in[0] = {12'h000, d};
        tick(4);
        check_val(name, 32'(exp ^ {DIR_W{ACTIVE_LOW}}), 32'(joy_out[0][DIR_W-1:0]));
    endtask

    task automatic pause_settle(string name, logic exp);
        tick(4);
        check_val(name, 32'(exp), 32'(game_pause));
    endtask

    // cycle model, runs 2 ns after each edge on the inputs of that edge
    always @(posedge clk_sys) begin
        #2;
        trig = p_rst | p_req | p_dl | m_soft;
        if (trig) begin
            m_cnt = 0;
            e_rst = 1'b1;
        end else if (m_cnt != GAME_RST_LEN) begin
            m_cnt++;
            e_rst = 1'b1;
        end else begin
            e_rst = 1'b0;
        end
        m_soft = !p_rst && p_kr && !m_lkr;
        m_lkr  = !p_rst && p_kr;
        if (p_rst) begin
            for (int p = 0; p < NUM_PLAYERS; p++) begin
                e_joy[p]  = {GAME_JOY_W{ACTIVE_LOW}};
                m_sync[p] = '0;
                m_dir[p]  = '0;
            end
            e_coin    = {NUM_PLAYERS{ACTIVE_LOW}};
            e_start   = {NUM_PLAYERS{ACTIVE_LOW}};
            e_pause   = 1'b0;
            e_service = ACTIVE_LOW;
            e_gfx     = '1;
            {m_lkp, m_ljp, m_losd, m_lgfx} = '0;
            {e_r, e_g, e_b, e_hs, e_vs, e_de} = '0;
        end else begin
            for (int p = 0; p < NUM_PLAYERS; p++) begin
                e_joy[p]   = joy_ref(m_sync[p][GAME_JOY_W-1:0], p_rot, p_flip);
                e_coin[p]  = m_sync[p][COIN_BIT] ^ ACTIVE_LOW;
                e_start[p] = m_sync[p][START_BIT] ^ ACTIVE_LOW;
            end
            jp        = m_sync[0][PAUSE_BIT] | m_sync[1][PAUSE_BIT];
            e_pause   = pause_ref(e_pause, p_dl, p_osd, m_losd, (p_kp & ~m_lkp) | (jp & ~m_ljp));
            m_ljp     = jp;
            m_lkp     = p_kp;
            m_losd    = p_osd;
            e_service = p_ks ^ ACTIVE_LOW;
            e_gfx     = e_gfx ^ (p_gfx & ~m_lgfx);
            m_lgfx    = p_gfx;
            for (int p = 0; p < NUM_PLAYERS; p++) begin
                m_dir[p]  = four_way_ref(p_en, p_joy[p][DIR_W-1:0], m_dir[p]);
                m_sync[p] = {p_joy[p][RAW_JOY_W-1:DIR_W], m_dir[p]};   // same edge for both
            end
            if (p_cen) begin
                e_r  = widen_ref(p_r);
                e_g  = widen_ref(p_g);
                e_b  = widen_ref(p_b);
                e_hs = p_hs;
                e_vs = p_vs;
                e_de = p_lhbl & p_lvbl;
            end
        end
        if (chk_on) begin
            for (int p = 0; p < NUM_PLAYERS; p++) begin
                check_val($sformatf("joystick%0d", p + 1), 32'(e_joy[p]), 32'(joy_out[p]));
            end
            check_val("coin", 32'(e_coin), 32'(game_coin));
            check_val("start", 32'(e_start), 32'(game_start));
            check_val("service", 32'(e_service), 32'(game_service));
            check_val("pause", 32'(e_pause), 32'(game_pause));
            check_val("gfx_en", 32'(e_gfx), 32'(gfx_en));
            check_val("game_rst", 32'(e_rst), 32'(game_rst));
            check_val("video rgb", {8'h00, e_r, e_g, e_b}, {8'h00, video_r, video_g, video_b});
            check_val("video sync", 32'({e_hs, e_vs, e_de}), 32'({video_hs, video_vs, video_de}));
        end
        {p_rst, p_req, p_dl} = {rst, rst_req, downloading};
        {p_en, p_rot, p_flip} = {en4way, rot_control, flip};
        {p_osd, p_kp, p_kr, p_ks, p_gfx} = {osd_pause, key_pause, key_reset, key_service, key_gfx};
        {p_cen, p_r, p_g, p_b} = {pxl_cen, game_r, game_g, game_b};
        {p_lhbl, p_lvbl, p_hs, p_vs} = {lhbl, lvbl, hs, vs};
        for (int p = 0; p < NUM_PLAYERS; p++) begin
            p_joy[p] = joy_in[p];
        end
    end

    always @(posedge clk_sys) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        {rst_req, downloading, en4way, rot_control, flip} = '0;
        {osd_pause, key_pause, key_reset, key_service, key_gfx} = '0;
        {game_r, game_g, game_b, lhbl, lvbl, hs, vs, pxl_cen} = '0;
        for (int p = 0; p < NUM_PLAYERS; p++) begin
            joy_in[p] = '0;
        end
        rst = 1'b1;
        tick(5);
        rst    = 1'b0;
        chk_on = 1'b1;

        count_stretch("stretch after rst");
        rst_req = 1'b1;
        tick(1);
        rst_req = 1'b0;
        count_stretch("stretch after rst_req");
        downloading = 1'b1;
        tick(1);
        downloading = 1'b0;
        count_stretch("stretch after downloading");

        // random words over the four rotation and flip settings
        for (int k = 0; k < N_JOY; k++) begin
            rot_control = ((k * 4 / N_JOY) & 2) != 0;
            flip        = ((k * 4 / N_JOY) & 1) != 0;
            for (int p = 0; p < NUM_PLAYERS; p++) begin
                joy_in[p] = 16'(rand_bits(16));
            end
            key_service = 1'(rand_bits(1));
            tick(1);
        end
        for (int p = 0; p < NUM_PLAYERS; p++) begin
            joy_in[p] = '0;
        end
        {rot_control, flip, key_service} = '0;
        en4way = 1'b1;
        tick(4);

        press_dir(4'b0001, 4'b0001, "4way right");
        press_dir(4'b1001, 4'b0001, "4way right up");
        press_dir(4'b1000, 4'b1000, "4way up");
        press_dir(4'b0000, 4'b0000, "4way idle");
        press_dir(4'b1001, 4'b0000, "4way fresh diagonal");
        joy_in[0] = '0;
        en4way    = 1'b0;

        downloading = 1'b1;
        tick(1);
        downloading = 1'b0;
        pause_settle("pause after download", 1'b0);
        key_pause = 1'b1;
        tick(2);
        key_pause = 1'b0;
        pause_settle("key pause", 1'b1);
        joy_in[1] = 16'h0001 << PAUSE_BIT;
        tick(3);
        joy_in[1] = '0;
        pause_settle("player 2 pause", 1'b0);
        osd_pause = 1'b1;
        pause_settle("osd pause on", 1'b1);
        key_pause = 1'b1;
        tick(2);
        key_pause = 1'b0;
        pause_settle("key pause under osd", 1'b0);
        key_pause = 1'b1;
        tick(2);
        key_pause = 1'b0;
        pause_settle("key pause again", 1'b1);
        osd_pause = 1'b0;
        pause_settle("osd pause off", 1'b0);
        key_pause = 1'b1;
        tick(2);
        key_pause = 1'b0;
        pause_settle("key pause after osd", 1'b1);
        downloading = 1'b1;
        tick(1);
        downloading = 1'b0;
        count_stretch("stretch after download");
        pause_settle("download clears pause", 1'b0);

        key_reset = 1'b1;
        tick(2);
        key_reset = 1'b0;
        count_stretch("soft reset stretch");
        key_gfx = 4'b0001;
        tick(2);
        key_gfx = 4'b0000;
        tick(1);
        key_gfx = 4'b0100;
        tick(2);
        key_gfx = 4'b0000;
        tick(2);
        check_val("gfx toggles", 32'h0000_000a, 32'(gfx_en));

        // colours with a pixel enable every third cycle
        for (int k = 0; k < N_COLOR; k++) begin
            pxl_cen = (k % 3) == 0;
            game_r  = COLORW'(rand_bits(COLORW));
            game_g  = COLORW'(rand_bits(COLORW));
            game_b  = COLORW'(rand_bits(COLORW));
            {lhbl, lvbl, hs, vs} = 4'(rand_bits(4));
            tick(1);
        end
        pxl_cen = 1'b0;
        tick(5);
        chk_on = 1'b0;

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== board.f ====
board_pkg.sv
board_reset.sv
joy_4way.sv
joy_mapper.sv
panel_ctrl.sv
color_expand.sv
board_top.sv
tb_board.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the board testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

if ! verilator --binary --assert -j 0 --top-module tb_board -f board.f -o tb_board; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_board > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "ALL TESTS PASSED" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
